//--- verilog/rv_defines.svh
// Data width, register count and NOP encoding macros for the RV32I pipeline slice
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data and address width
`define RV_XLEN 32

// Architectural register count
`define RV_NREGS 32

// ADDI x0,x0,0
`define RV_NOP 32'h0000_0013

`endif

//--- verilog/rv_pkg.sv
// Package with RV32I opcodes, control enums, stage structs and immediate generation
`include "rv_defines.svh"
`default_nettype none

package rv_pkg;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011; // Not executed, only its immediate format
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
    } alu_op_e;

    typedef enum logic [3:0] {
        CFU_NONE, CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE,
        CFU_BLTU, CFU_BGEU, CFU_JAL, CFU_JALR
    } cfu_op_e;

    typedef enum logic {OPR_A_REG, OPR_A_PC}  opr_a_sel_e;
    typedef enum logic {OPR_B_REG, OPR_B_IMM} opr_b_sel_e;
    typedef enum logic {WB_ALU, WB_PC4}       wb_sel_e;

    // Valid is the first field of every stage payload, pipe_reg relies on it
    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         inst;
    } id_stage_in_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] pc4;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] opr_a;
        logic [`RV_XLEN-1:0] opr_b;
        logic [`RV_XLEN-1:0] imm;
        alu_op_e             aluop;
        cfu_op_e             cfuop;
        logic                rf_en;
        opr_a_sel_e          opr_a_sel;
        opr_b_sel_e          opr_b_sel;
        wb_sel_e             wb_sel;
    } id_stage_out_t;

    typedef struct packed {
        logic                valid;
        logic                rf_en;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] wb_data;
    } ex_stage_out_t;

    typedef struct packed {
        logic                rf_en; // Already qualified by valid
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] wb_data;
    } wb_stage_out_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] target;
    } redirect_t;

    function automatic logic [`RV_XLEN-1:0] gen_imm_f(input logic [31:0] inst);
        logic [`RV_XLEN-1:0] imm;
        imm = '0;
        case (inst[6:0])
            OPC_OP_IMM, OPC_JALR, OPC_LOAD: imm = {{20{inst[31]}}, inst[31:20]};
            OPC_STORE:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            OPC_BRANCH: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC: imm = {inst[31:12], 12'b0};
            OPC_JAL:    imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default:    imm = '0; // R-type and unknown opcodes carry no immediate
        endcase
        return imm;
    endfunction

endpackage

`default_nettype wire

//--- verilog/rf.sv
// Register file with two read ports, one write port and write-through bypass
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rf #(
    parameter int DATA_WIDTH = `RV_XLEN,
    parameter int NREGS      = `RV_NREGS
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr_en,
    input  logic [$clog2(NREGS)-1:0] rd,
    input  logic [DATA_WIDTH-1:0]    rd_data,
    input  logic [$clog2(NREGS)-1:0] rs1,
    input  logic [$clog2(NREGS)-1:0] rs2,
    output logic [DATA_WIDTH-1:0]    rs1_data,
    output logic [DATA_WIDTH-1:0]    rs2_data
);
    logic [DATA_WIDTH-1:0] regs [NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && rd != '0) begin // x0 stays zero
            regs[rd] <= rd_data;
        end
    end

    // A read of the register being written sees the new value
    assign rs1_data = (wr_en && rd == rs1 && rs1 != '0) ? rd_data : regs[rs1];
    assign rs2_data = (wr_en && rd == rs2 && rs2 != '0) ? rd_data : regs[rs2];

endmodule

`default_nettype wire

//--- verilog/ctrl_unit.sv
// Control unit mapping opcode, funct3 and funct7 to the decode control fields
`timescale 1ns/1ps
`default_nettype none

module ctrl_unit
    import rv_pkg::*;
(
    input  logic [6:0]  opcode,
    input  logic [2:0]  funct3,
    input  logic [6:0]  funct7,
    output alu_op_e     aluop,
    output cfu_op_e     cfuop,
    output logic        rf_en,
    output opr_a_sel_e  opr_a_sel,
    output opr_b_sel_e  opr_b_sel,
    output wb_sel_e     wb_sel
);
    logic f7_zero;
    logic f7_alt;

    // Alternate encoding selects SUB or SRA
    function automatic alu_op_e alu_dec_f(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    always_comb begin
        aluop     = ALU_ADD;
        cfuop     = CFU_NONE;
        rf_en     = 1'b0;
        opr_a_sel = OPR_A_REG;
        opr_b_sel = OPR_B_REG;
        wb_sel    = WB_ALU;
        case (opcode)
            OPC_OP: begin
                if (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    rf_en = 1'b1;
                    aluop = alu_dec_f(funct3, f7_alt);
                end
            end
            OPC_OP_IMM: begin
                // Only the shift forms constrain funct7
                if ((funct3 != 3'b001 && funct3 != 3'b101) || f7_zero ||
                    (funct3 == 3'b101 && f7_alt)) begin
                    rf_en     = 1'b1;
                    opr_b_sel = OPR_B_IMM;
                    aluop     = alu_dec_f(funct3, funct3 == 3'b101 && f7_alt);
                end
            end
            OPC_LUI: begin
                rf_en     = 1'b1;
                opr_b_sel = OPR_B_IMM;
                aluop     = ALU_PASSB;
            end
            OPC_AUIPC: begin
                rf_en     = 1'b1;
                opr_a_sel = OPR_A_PC;
                opr_b_sel = OPR_B_IMM;
            end
            OPC_JAL: begin
                rf_en     = 1'b1;
                cfuop     = CFU_JAL;
                opr_a_sel = OPR_A_PC;
                opr_b_sel = OPR_B_IMM;
                wb_sel    = WB_PC4;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    rf_en     = 1'b1;
                    cfuop     = CFU_JALR;
                    opr_b_sel = OPR_B_IMM;
                    wb_sel    = WB_PC4;
                end
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  cfuop = CFU_BEQ;
                    3'b001:  cfuop = CFU_BNE;
                    3'b100:  cfuop = CFU_BLT;
                    3'b101:  cfuop = CFU_BGE;
                    3'b110:  cfuop = CFU_BLTU;
                    3'b111:  cfuop = CFU_BGEU;
                    default: cfuop = CFU_NONE;
                endcase
            end
            default: ; // Unsupported, becomes a bubble
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/id_stage.sv
// Decode stage with register file, control unit and immediate generation
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module id_stage
    import rv_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  wb_stage_out_t wb_in,
    input  id_stage_in_t  id_stage_in,
    output id_stage_out_t id_stage_out
);
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign rs1    = id_stage_in.inst[19:15];
    assign rs2    = id_stage_in.inst[24:20];
    assign opcode = id_stage_in.inst[6:0];
    assign funct3 = id_stage_in.inst[14:12];
    assign funct7 = id_stage_in.inst[31:25];

    rf #(
        .DATA_WIDTH (`RV_XLEN ),
        .NREGS      (`RV_NREGS)
    ) u_rf (
        .clk      (clk               ),
        .reset    (reset             ),
        .wr_en    (wb_in.rf_en       ), // Writeback from the end of the pipe
        .rd       (wb_in.rd          ),
        .rd_data  (wb_in.wb_data     ),
        .rs1      (rs1               ),
        .rs2      (rs2               ),
        .rs1_data (id_stage_out.opr_a),
        .rs2_data (id_stage_out.opr_b)
    );

    ctrl_unit u_ctrl_unit (
        .opcode    (opcode                ),
        .funct3    (funct3                ),
        .funct7    (funct7                ),
        .aluop     (id_stage_out.aluop    ),
        .cfuop     (id_stage_out.cfuop    ),
        .rf_en     (id_stage_out.rf_en    ),
        .opr_a_sel (id_stage_out.opr_a_sel),
        .opr_b_sel (id_stage_out.opr_b_sel),
        .wb_sel    (id_stage_out.wb_sel   )
    );

    assign id_stage_out.valid = id_stage_in.valid;
    assign id_stage_out.pc    = id_stage_in.pc;
    assign id_stage_out.pc4   = id_stage_in.pc + `RV_XLEN'd4; // Link address for jumps
    assign id_stage_out.rd    = id_stage_in.inst[11:7];
    assign id_stage_out.imm   = gen_imm_f(id_stage_in.inst);

endmodule

`default_nettype wire

//--- verilog/ex_stage.sv
// Execute stage with ALU, branch compare, target computation and writeback select
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module ex_stage
    import rv_pkg::*;
(
    input  id_stage_out_t ex_in,
    output ex_stage_out_t ex_out,
    output redirect_t     redirect
);
    logic [`RV_XLEN-1:0] opa;
    logic [`RV_XLEN-1:0] opb;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] alu_res;
    logic                eq;
    logic                lt;
    logic                ltu;
    logic                taken;
    logic                jump;

    assign opa   = (ex_in.opr_a_sel == OPR_A_PC)  ? ex_in.pc  : ex_in.opr_a;
    assign opb   = (ex_in.opr_b_sel == OPR_B_IMM) ? ex_in.imm : ex_in.opr_b;
    assign shamt = opb[4:0];

    always_comb begin
        case (ex_in.aluop)
            ALU_ADD:   alu_res = opa + opb;
            ALU_SUB:   alu_res = opa - opb;
            ALU_SLL:   alu_res = opa << shamt;
            ALU_SLT:   alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            ALU_SLTU:  alu_res = {{(`RV_XLEN-1){1'b0}}, opa < opb};
            ALU_XOR:   alu_res = opa ^ opb;
            ALU_SRL:   alu_res = opa >> shamt;
            ALU_SRA:   alu_res = $unsigned($signed(opa) >>> shamt);
            ALU_OR:    alu_res = opa | opb;
            ALU_AND:   alu_res = opa & opb;
            ALU_PASSB: alu_res = opb;
            default:   alu_res = '0;
        endcase
    end

    // Branches always compare the two register values
    assign eq  = (ex_in.opr_a == ex_in.opr_b);
    assign lt  = ($signed(ex_in.opr_a) < $signed(ex_in.opr_b));
    assign ltu = (ex_in.opr_a < ex_in.opr_b);

    always_comb begin
        case (ex_in.cfuop)
            CFU_BEQ:  taken = eq;
            CFU_BNE:  taken = !eq;
            CFU_BLT:  taken = lt;
            CFU_BGE:  taken = !lt;
            CFU_BLTU: taken = ltu;
            CFU_BGEU: taken = !ltu;
            default:  taken = 1'b0;
        endcase
    end

    assign jump = (ex_in.cfuop == CFU_JAL) || (ex_in.cfuop == CFU_JALR);

    assign redirect.valid  = ex_in.valid && (jump || taken);
    assign redirect.target = (ex_in.cfuop == CFU_JALR) ? {alu_res[`RV_XLEN-1:1], 1'b0}
                                                       : ex_in.pc + ex_in.imm;

    assign ex_out.valid   = ex_in.valid;
    assign ex_out.rf_en   = ex_in.rf_en;
    assign ex_out.rd      = ex_in.rd;
    assign ex_out.wb_data = (ex_in.wb_sel == WB_PC4) ? ex_in.pc4 : alu_res;

endmodule

`default_nettype wire

//--- verilog/pipe_reg.sv
// Pipeline register over a generic payload with valid clear on reset or flush
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type T = logic [7:0]
) (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  T     d,
    output T     q
);
    // Valid is the top bit of the payload
    localparam int VALID_BIT = $bits(T) - 1;

    always_ff @(posedge clk) begin
        q <= d;
        if (reset || flush) begin
            q[VALID_BIT] <= 1'b0; // Payload is left as is, only the item is dropped
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
// Top level wiring decode, two pipeline registers and execute
`timescale 1ns/1ps
`default_nettype none

module rv_core
    import rv_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  id_stage_in_t  id_in,
    output wb_stage_out_t wb,
    output redirect_t     redirect
);
    id_stage_out_t id_out;
    id_stage_out_t ex_in;
    ex_stage_out_t ex_out;
    ex_stage_out_t ex_wb;

    id_stage u_id_stage (
        .clk          (clk   ),
        .reset        (reset ),
        .wb_in        (wb    ),
        .id_stage_in  (id_in ),
        .id_stage_out (id_out)
    );

    // Squashed by a taken branch or jump in execute
    pipe_reg #(.T(id_stage_out_t)) u_id_ex (
        .clk   (clk           ),
        .reset (reset         ),
        .flush (redirect.valid),
        .d     (id_out        ),
        .q     (ex_in         )
    );

    ex_stage u_ex_stage (
        .ex_in    (ex_in   ),
        .ex_out   (ex_out  ),
        .redirect (redirect)
    );

    pipe_reg #(.T(ex_stage_out_t)) u_ex_wb (
        .clk   (clk   ),
        .reset (reset ),
        .flush (1'b0  ),
        .d     (ex_out),
        .q     (ex_wb )
    );

    assign wb.rf_en   = ex_wb.valid & ex_wb.rf_en;
    assign wb.rd      = ex_wb.rd;
    assign wb.wb_data = ex_wb.wb_data;

endmodule

`default_nettype wire

//--- dv/rv_core_chk.sv
// Concurrent assertions on the rv_core outputs and their bind into the top level
`timescale 1ns/1ps
`default_nettype none

module rv_core_chk
    import rv_pkg::*;
(
    input logic          clk,
    input logic          reset,
    input wb_stage_out_t wb,
    input redirect_t     redirect
);
    // Both pipeline valids come out of reset cleared
    idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !wb.rf_en && !redirect.valid)
        else $error("Outputs not idle in the first cycle after reset");

    no_back_to_back_redirect: assert property (@(posedge clk) disable iff (reset)
        redirect.valid |=> !redirect.valid) // Second one was squashed
        else $error("Redirect valid in two consecutive cycles");

    wb_data_known: assert property (@(posedge clk) disable iff (reset)
        wb.rf_en |-> !$isunknown(wb.wb_data))
        else $error("Writeback data has unknown bits");

endmodule

bind rv_core rv_core_chk u_rv_core_chk (
    .clk      (clk     ),
    .reset    (reset   ),
    .wb       (wb      ),
    .redirect (redirect)
);

`default_nettype wire

//--- dv/rv_core_tb.sv
// Testbench for rv_core with a register model, directed test tasks, check task and timeout
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_core_tb
    import rv_pkg::*;
();
    localparam int TIMEOUT_CYCLES = 400;

    logic          clk;
    logic          reset;
    id_stage_in_t  id_in;
    wb_stage_out_t wb;
    redirect_t     redirect;

    logic [31:0]   model [32];   // Architectural register values
    wb_stage_out_t exp_wb [512]; // Expected writeback, indexed by cycle
    redirect_t     exp_br [512]; // Expected redirect, indexed by cycle
    int            cyc = 0;
    logic [31:0]   pc;
    logic [31:0]   rng;

    rv_core u_rv_core (
        .clk      (clk     ),
        .reset    (reset   ),
        .id_in    (id_in   ),
        .wb       (wb      ),
        .redirect (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Integer results as the RV32I spec defines them
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0]; // Sign bit fills from the left
                end
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input logic alt, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (cyc > 0) begin
            check("wb.rf_en", 32'(exp_wb[cyc[8:0]].rf_en), 32'(wb.rf_en));
            if (exp_wb[cyc[8:0]].rf_en) begin
                check("wb.rd", 32'(exp_wb[cyc[8:0]].rd), 32'(wb.rd));
                check("wb.wb_data", exp_wb[cyc[8:0]].wb_data, wb.wb_data);
            end
            check("redirect.valid", 32'(exp_br[cyc[8:0]].valid), 32'(redirect.valid));
            if (exp_br[cyc[8:0]].valid) begin
                check("redirect.target", exp_br[cyc[8:0]].target, redirect.target);
            end
        end
    end

    // Presents one instruction and books its writeback two cycles and redirect one cycle later
    task automatic step(input logic [31:0] inst, input logic we, input logic [31:0] data,
                        input logic br, input logic [31:0] tgt);
        logic [8:0] n;
        logic       squashed;
        @(posedge clk);
        #1;
        n        = cyc[8:0];
        squashed = exp_br[n].valid; // The previous item redirects, so this one is dropped
        id_in    = '{valid: 1'b1, pc: pc, inst: inst};
        if (!squashed) begin
            exp_wb[n + 9'd2] = '{rf_en: we, rd: inst[11:7], wb_data: data};
            exp_br[n + 9'd1] = '{valid: br, target: tgt};
            if (we && inst[11:7] != 5'd0) begin
                model[inst[11:7]] = data;
            end
        end
        pc = squashed ? exp_br[n].target : pc + 32'd4;
    endtask

    task automatic idle(input int k);
        repeat (k) begin
            @(posedge clk);
            #1;
            id_in.valid = 1'b0;
        end
    endtask

    task automatic alu(input logic [31:0] inst, input logic [31:0] data);
        step(inst, 1'b1, data, 1'b0, 32'd0);
    endtask

    task automatic nop();
        alu(`RV_NOP, 32'd0);
    endtask

    task automatic load_reg(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] upper;
        upper = (val + 32'h800) & 32'hffff_f000; // Rounded so the ADDI low part sign extends
        alu({upper[31:12], rd, OPC_LUI}, upper);
        nop();
        alu(enc_i(val[11:0], rd, 3'd0, rd, OPC_OP_IMM), model[rd] + {{20{val[11]}}, val[11:0]});
        nop();
    endtask

    task automatic test_reset_x0();
        idle(3);
        for (int r = 0; r < 32; r++) begin
            alu(enc_i(12'd0, 5'(r), 3'd0, 5'(r), OPC_OP_IMM), 32'd0);
        end
        alu(enc_i(12'h123, 5'd0, 3'd0, 5'd0, OPC_OP_IMM), 32'h123); // Visible at wb only
        nop();
        alu(enc_i(12'd0, 5'd0, 3'd0, 5'd4, OPC_OP_IMM), 32'd0);
        alu(enc_i(12'd0, 5'd0, 3'd0, 5'd5, OPC_OP_IMM), 32'd0); // After the x0 write edge
    endtask

    task automatic test_alu();
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [31:0] r;
        load_reg(5'd1, next_random() & 32'h7fff_ffff);
        load_reg(5'd2, next_random());
        load_reg(5'd3, next_random() | 32'h8000_0000); // Negative for SRA and signed compare
        for (int p = 0; p < 2; p++) begin
            rs1 = (p == 0) ? 5'd1 : 5'd3;
            rs2 = (p == 0) ? 5'd2 : 5'd1;
            for (int f = 0; f < 10; f++) begin
                f3  = (f < 8) ? 3'(f) : ((f == 8) ? 3'd0 : 3'd5); // SUB and SRA last
                alt = (f >= 8);
                alu(enc_r(alt, rs2, rs1, f3, 5'(10 + f)),
                    alu_ref(f3, alt, model[rs1], model[rs2]));
            end
            for (int f = 0; f < 9; f++) begin
                r   = next_random();
                f3  = (f < 8) ? 3'(f) : 3'd5;
                alt = (f == 8);
                imm = (f3 == 3'd1 || f3 == 3'd5) ? {1'b0, alt, 5'b0, r[4:0]} : r[11:0];
                alu(enc_i(imm, rs1, f3, 5'(20 + f), OPC_OP_IMM),
                    alu_ref(f3, alt, model[rs1], {{20{imm[11]}}, imm}));
            end
        end
    endtask

    task automatic test_upper();
        logic [31:0] r;
        r = next_random();
        alu({r[31:12], 5'd5, OPC_LUI}, {r[31:12], 12'b0});
        nop();
        alu(enc_i(12'h7ff, 5'd5, 3'd0, 5'd6, OPC_OP_IMM), model[5] + 32'h7ff); // Via bypass
        r = next_random();
        alu({r[31:12], 5'd7, OPC_AUIPC}, pc + {r[31:12], 12'b0});
        nop();
        alu(enc_r(1'b0, 5'd7, 5'd5, 3'd0, 5'd8), model[5] + model[7]);
    endtask

    task automatic test_branches();
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [12:0] imm;
        logic [31:0] r;
        logic        taken;
        for (int f = 0; f < 6; f++) begin
            f3 = (f < 2) ? 3'(f) : 3'(f + 2);
            // Pairs x1,x1 then x1,x3 then x3,x1 give each condition both outcomes
            for (int k = 0; k < 3; k++) begin
                rs1   = (k == 2) ? 5'd3 : 5'd1;
                rs2   = (k == 1) ? 5'd3 : 5'd1;
                r     = next_random();
                imm   = {r[11:0], 1'b0};
                taken = br_ref(f3, model[rs1], model[rs2]);
                step(enc_b(imm, rs2, rs1, f3), 1'b0, 32'd0, taken, pc + {{19{imm[12]}}, imm});
                alu(enc_i(12'd1, 5'd0, 3'd0, 5'd9, OPC_OP_IMM), 32'd1);
            end
        end
    endtask

    task automatic test_jumps();
        logic [31:0] r;
        logic [20:0] jimm;
        logic [11:0] imm;
        r    = next_random();
        jimm = {r[19:0], 1'b0};
        step(enc_j(jimm, 5'd11), 1'b1, pc + 32'd4, 1'b1, pc + {{11{jimm[20]}}, jimm});
        // A jump in the shadow would redirect again if it were not squashed
        step(enc_j(jimm, 5'd9), 1'b1, pc + 32'd4, 1'b1, pc + {{11{jimm[20]}}, jimm});
        load_reg(5'd13, next_random() | 32'd1); // Odd base so the sum has bit 0 set
        r   = next_random();
        imm = {r[11:1], 1'b0};
        step(enc_i(imm, 5'd13, 3'd0, 5'd12, OPC_JALR), 1'b1, pc + 32'd4, 1'b1,
             (model[13] + {{20{imm[11]}}, imm}) & ~32'd1);
        alu(enc_i(12'd1, 5'd0, 3'd0, 5'd9, OPC_OP_IMM), 32'd1);
        nop();
    endtask

    task automatic test_store();
        step({7'd0, 5'd1, 5'd2, 3'b010, 5'd8, OPC_STORE}, 1'b0, 32'd0, 1'b0, 32'd0);
        nop();
    endtask

    initial begin
        rng    = 32'hb88e2f85;
        pc     = 32'h0000_1000;
        model  = '{default: '0};
        exp_wb = '{default: '0};
        exp_br = '{default: '0};
        id_in  = '0;
        reset  = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_x0();
        test_alu();
        test_upper();
        test_branches();
        test_jumps();
        test_store();
        idle(3);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rf.sv
verilog/ctrl_unit.sv
verilog/id_stage.sv
verilog/ex_stage.sv
verilog/pipe_reg.sv
verilog/rv_core.sv
dv/rv_core_chk.sv
dv/rv_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for the fail message
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module rv_core_tb -f files.f \
    && ./obj_dir/Vrv_core_tb 2>&1 | tee sim.log \
    && ! grep -q "Test FAILED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
